// File: files.f
verilog/btac_pkg.sv
verilog/btb_if.sv
verilog/btb.sv
verilog/btac_lookup.sv
verilog/btac_resolve.sv
verilog/btac.sv
verification/btac_chk.sv
verification/btac_tb.sv

// File: Bender.yml
package:
  name: btac

sources:
  - verilog/btac_pkg.sv
  - verilog/btb_if.sv
  - verilog/btb.sv
  - verilog/btac_lookup.sv
  - verilog/btac_resolve.sv
  - verilog/btac.sv
  - target: test
    files:
      - verification/btac_chk.sv
      - verification/btac_tb.sv

// File: verification/btac_tb.sv
module btac_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [btac_pkg::xlen-1:0] word_t;

  // well above the length of the stimulus below
  localparam int max_cycles = 400;

  logic clock;
  logic reset;
  logic stall;
  logic clear;
  word_t get_pc0, get_pc1;
  word_t upd_pc0, upd_npc0, upd_addr0;
  word_t upd_pc1, upd_npc1, upd_addr1;
  logic upd_jal0, upd_branch0, upd_jump0;
  logic upd_jal1, upd_branch1, upd_jump1;
  logic fetch_taken, decode_taken, issue_taken, execute_taken, memory_taken;
  word_t fetch_taddr, fetch_tpc, fetch_tnpc;
  word_t decode_taddr, decode_tpc, decode_tnpc;
  word_t issue_taddr, issue_tpc, issue_tnpc;
  word_t execute_taddr, execute_tpc, execute_tnpc;
  word_t memory_taddr, memory_tpc, memory_tnpc;
  logic pred_branch;
  word_t pred_baddr, pred_pc, pred_npc;
  logic pred_miss;
  word_t pred_maddr;

  // expected buffer contents, written whenever an update should reach the array
  word_t model_target [btac_pkg::btb_entries];
  word_t model_pc [btac_pkg::btb_entries];
  word_t model_npc [btac_pkg::btb_entries];

  integer seed;
  int checks = 0;
  int errors = 0;
  int cycles = 0;
  word_t pa, pb, pc, pd, pf, pg, p1, p2, p3, p4;
  word_t ta, tc, td, tf, tg, t1, t2, t3, t4;

  btac dut_i (.*);

  initial begin
    clock = 1'b0;
  end

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the test sequence did not finish within %0d cycles", max_cycles);
      print_counts();
      $display("sim failed");
      $finish;
    end
  end

  function automatic word_t rand_word();
    word_t r;
    r = $random(seed);
    r[1:0] = 2'b00; // word aligned
    return r;
  endfunction

  function automatic word_t rand_pc(input int idx);
    word_t r;
    r = rand_word();
    r[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb] = idx[btac_pkg::btb_index_width-1:0];
    return r;
  endfunction

  task automatic print_counts();
    $display("checks: %0d, value errors: %0d, assertion failures: %0d",
             checks, errors, dut_i.chk_i.fail_count);
  endtask

  task automatic expect_value(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_idle();
    stall <= 1'b0;
    clear <= 1'b0;
    {get_pc0, get_pc1} <= '0;
    {upd_pc0, upd_npc0, upd_addr0, upd_jal0, upd_branch0, upd_jump0} <= '0;
    {upd_pc1, upd_npc1, upd_addr1, upd_jal1, upd_branch1, upd_jump1} <= '0;
    {fetch_taken, fetch_taddr, fetch_tpc, fetch_tnpc} <= '0;
    {decode_taken, decode_taddr, decode_tpc, decode_tnpc} <= '0;
    {issue_taken, issue_taddr, issue_tpc, issue_tnpc} <= '0;
    {execute_taken, execute_taddr, execute_tpc, execute_tnpc} <= '0;
    {memory_taken, memory_taddr, memory_tpc, memory_tnpc} <= '0;
  endtask

  task automatic drive_slot(input logic slot, input logic jal, input logic branch,
                            input logic jump, input word_t pc, input word_t npc,
                            input word_t addr);
    if (slot == 1'b0) begin
      {upd_pc0, upd_npc0, upd_addr0} <= {pc, npc, addr};
      {upd_jal0, upd_branch0, upd_jump0} <= {jal, branch, jump};
    end else begin
      {upd_pc1, upd_npc1, upd_addr1} <= {pc, npc, addr};
      {upd_jal1, upd_branch1, upd_jump1} <= {jal, branch, jump};
    end
  endtask

  // stage 0 is fetch and stage 4 is memory
  task automatic drive_stage(input int stage, input word_t taddr, input word_t tpc,
                             input word_t tnpc);
    case (stage)
      0: {fetch_taken, fetch_taddr, fetch_tpc, fetch_tnpc} <= {1'b1, taddr, tpc, tnpc};
      1: {decode_taken, decode_taddr, decode_tpc, decode_tnpc} <= {1'b1, taddr, tpc, tnpc};
      2: {issue_taken, issue_taddr, issue_tpc, issue_tnpc} <= {1'b1, taddr, tpc, tnpc};
      3: {execute_taken, execute_taddr, execute_tpc, execute_tnpc} <= {1'b1, taddr, tpc, tnpc};
      default: {memory_taken, memory_taddr, memory_tpc, memory_tnpc} <= {1'b1, taddr, tpc, tnpc};
    endcase
  endtask

  task automatic store(input word_t pc, input word_t npc, input word_t addr);
    int idx;
    idx = pc[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
    model_target[idx] = addr;
    model_pc[idx] = pc;
    model_npc[idx] = npc;
  endtask

  task automatic lookup(input word_t pc0, input word_t pc1, input logic stall_on,
                        input logic clear_on);
    int i0;
    int i1;
    int sel;
    logic h0;
    logic h1;
    i0 = pc0[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
    i1 = pc1[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
    h0 = (|{model_target[i0], model_pc[i0], model_npc[i0]}) && (model_pc[i0] == pc0);
    h1 = (|{model_target[i1], model_pc[i1], model_npc[i1]}) && (model_pc[i1] == pc1);
    sel = h0 ? i0 : i1; // without a slot 0 hit the fields come from slot 1
    @(posedge clock);
    drive_idle();
    get_pc0 <= pc0;
    get_pc1 <= pc1;
    @(posedge clock);
    drive_idle();
    stall <= stall_on;
    clear <= clear_on;
    @(negedge clock);
    if (stall_on || clear_on) begin
      expect_value("gated pred_branch", pred_branch, 1'b0);
      expect_value("gated pred_baddr", pred_baddr, '0);
      expect_value("gated pred_pc", pred_pc, '0);
      expect_value("gated pred_npc", pred_npc, '0);
    end else begin
      expect_value("pred_branch", pred_branch, h0 | h1);
      expect_value("pred_baddr", pred_baddr, model_target[sel]);
      expect_value("pred_pc", pred_pc, model_pc[sel]);
      expect_value("pred_npc", pred_npc, model_npc[sel]);
    end
    expect_value("pred_miss during lookup", pred_miss, 1'b0);
  endtask

  task automatic resolve(input logic slot, input logic jump, input logic branch,
                         input word_t pc, input word_t addr, input logic clear_on,
                         input logic exp_miss, input word_t exp_maddr);
    @(posedge clock);
    drive_idle();
    drive_slot(slot, jump, branch, jump, pc, pc + 4, addr);
    clear <= clear_on;
    if (jump && !clear_on) begin
      store(pc, pc + 4, addr);
    end
    @(negedge clock);
    expect_value("pred_miss", pred_miss, exp_miss);
    expect_value("pred_maddr", pred_maddr, exp_maddr);
  endtask

  task automatic resolve_both(input word_t pc0, input word_t addr0, input word_t pc1,
                              input word_t addr1);
    @(posedge clock);
    drive_idle();
    drive_slot(1'b0, 1'b1, 1'b0, 1'b1, pc0, pc0 + 4, addr0);
    drive_slot(1'b1, 1'b1, 1'b0, 1'b1, pc1, pc1 + 4, addr1);
    store(pc0, pc0 + 4, addr0); // slot 0 owns the write
    @(negedge clock);
    expect_value("pred_miss on two jumps", pred_miss, 1'b1);
    expect_value("pred_maddr on two jumps", pred_maddr, addr0);
  endtask

  task automatic report(input int stage, input word_t taddr, input word_t tpc,
                        input logic with_fetch);
    @(posedge clock);
    drive_idle();
    if (with_fetch) begin
      drive_stage(0, ~taddr, tpc ^ 32'h0100_0000, ~tpc);
    end
    drive_stage(stage, taddr, tpc, tpc + 4);
    @(negedge clock);
    expect_value("pred_miss on a taken report", pred_miss, 1'b0);
  endtask

  initial begin
    seed = 32'h21ed6588;
    for (int i = 0; i < btac_pkg::btb_entries; i++) begin
      model_target[i] = '0;
      model_pc[i] = '0;
      model_npc[i] = '0;
    end
    drive_idle();
    reset = 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;

    {pa, pb, pc, pd, pf} = {rand_pc(5), rand_pc(6), rand_pc(7), rand_pc(9), rand_pc(17)};
    {pg, p1, p2, p3, p4} = {rand_pc(18), rand_pc(33), rand_pc(34), rand_pc(35), rand_pc(36)};
    {ta, tc, td, tf, tg} = {rand_word(), rand_word(), rand_word(), rand_word(), rand_word()};
    {t1, t2, t3, t4} = {rand_word(), rand_word(), rand_word(), rand_word()};

    repeat (3) lookup(rand_word(), rand_word(), 1'b0, 1'b0); // empty array

    resolve(1'b0, 1'b1, 1'b0, pa, ta, 1'b0, 1'b1, ta);
    lookup(pa, pb, 1'b0, 1'b0);
    lookup(pb, pa, 1'b0, 1'b0);
    resolve(1'b1, 1'b1, 1'b0, pc, tc, 1'b0, 1'b1, tc);
    lookup(pa, pc, 1'b0, 1'b0);
    lookup(pa ^ 32'h0010_0000, pc ^ 32'h0010_0000, 1'b0, 1'b0); // same index, other tag

    lookup(pa, pc, 1'b1, 1'b0);
    lookup(pa, pc, 1'b0, 1'b1);
    resolve(1'b0, 1'b1, 1'b0, pd, td, 1'b1, 1'b0, '0);
    lookup(pd, pd, 1'b0, 1'b0);

    resolve_both(pf, tf, pg, tg);
    lookup(pf, pg, 1'b0, 1'b0);

    report(4, t1, p1, 1'b1);
    resolve(1'b0, 1'b1, 1'b0, p1, t1, 1'b0, 1'b0, t1);
    report(3, t2, p2, 1'b0);
    resolve(1'b1, 1'b1, 1'b0, p2, t2 + 16, 1'b0, 1'b1, t2 + 16);
    report(2, t3, p3, 1'b0);
    resolve(1'b0, 1'b0, 1'b1, p3, t3, 1'b0, 1'b1, p3 + 4);
    resolve(1'b0, 1'b1, 1'b0, p3, t3, 1'b0, 1'b1, t3); // the branch above used up the record
    report(1, t4, p4, 1'b0);
    resolve(1'b1, 1'b1, 1'b0, p4, t4, 1'b0, 1'b0, t4);

    @(posedge clock);
    drive_idle();
    repeat (2) @(posedge clock);
    print_counts();
    if (errors == 0 && dut_i.chk_i.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verification/btac_chk.sv
module btac_chk (
  input logic clock,
  input logic reset,
  input logic stall,
  input logic clear,
  input logic [btac_pkg::xlen-1:0] get_pc0,
  input logic [btac_pkg::xlen-1:0] get_pc1,
  input logic upd_branch0,
  input logic upd_jump0,
  input logic upd_branch1,
  input logic upd_jump1,
  input logic wen,
  input logic pred_branch,
  input logic [btac_pkg::xlen-1:0] pred_baddr,
  input logic [btac_pkg::xlen-1:0] pred_pc,
  input logic [btac_pkg::xlen-1:0] pred_npc,
  input logic pred_miss,
  input logic [btac_pkg::xlen-1:0] pred_maddr
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  a_gate: assert property (@(posedge clock) disable iff (!reset)
    (stall || clear) |-> (!pred_branch && pred_baddr == '0 && pred_pc == '0 && pred_npc == '0))
    else begin
      fail_count++;
      $error("prediction outputs not zero under stall or clear");
    end

  a_clear_miss: assert property (@(posedge clock) disable iff (!reset)
    clear |-> (!pred_miss && pred_maddr == '0))
    else begin
      fail_count++;
      $error("misprediction raised while clear is high");
    end

  a_clear_write: assert property (@(posedge clock) disable iff (!reset)
    clear |-> !wen)
    else begin
      fail_count++;
      $error("buffer written while clear is high");
    end

  // only a resolved jump may write the buffer
  a_write_cause: assert property (@(posedge clock) disable iff (!reset)
    wen |-> (upd_jump0 || upd_jump1))
    else begin
      fail_count++;
      $error("buffer written without a resolved jump");
    end

  a_miss_cause: assert property (@(posedge clock) disable iff (!reset)
    !(upd_jump0 || upd_jump1 || upd_branch0 || upd_branch1) |-> !pred_miss)
    else begin
      fail_count++;
      $error("misprediction raised with no resolved branch");
    end

  // a hit always belongs to one of the two PCs looked up a cycle earlier
  a_hit_pc: assert property (@(posedge clock) disable iff (!reset)
    (pred_branch && !$past(clear)) |->
      (pred_pc == $past(get_pc0) || pred_pc == $past(get_pc1)))
    else begin
      fail_count++;
      $error("predicted PC matches neither fetch PC");
    end

endmodule

bind btac btac_chk chk_i (
  .*,
  .wen (btb_bus.wen)
);

// File: verilog/btac.sv
module btac (
  input logic clock,
  input logic reset,
  input logic stall,
  input logic clear,
  input logic [btac_pkg::xlen-1:0] get_pc0,
  input logic [btac_pkg::xlen-1:0] get_pc1,
  input logic [btac_pkg::xlen-1:0] upd_pc0,
  input logic [btac_pkg::xlen-1:0] upd_npc0,
  input logic [btac_pkg::xlen-1:0] upd_addr0,
  input logic upd_jal0,
  input logic upd_branch0,
  input logic upd_jump0,
  input logic [btac_pkg::xlen-1:0] upd_pc1,
  input logic [btac_pkg::xlen-1:0] upd_npc1,
  input logic [btac_pkg::xlen-1:0] upd_addr1,
  input logic upd_jal1,
  input logic upd_branch1,
  input logic upd_jump1,
  input logic fetch_taken,
  input logic [btac_pkg::xlen-1:0] fetch_taddr,
  input logic [btac_pkg::xlen-1:0] fetch_tpc,
  input logic [btac_pkg::xlen-1:0] fetch_tnpc,
  input logic decode_taken,
  input logic [btac_pkg::xlen-1:0] decode_taddr,
  input logic [btac_pkg::xlen-1:0] decode_tpc,
  input logic [btac_pkg::xlen-1:0] decode_tnpc,
  input logic issue_taken,
  input logic [btac_pkg::xlen-1:0] issue_taddr,
  input logic [btac_pkg::xlen-1:0] issue_tpc,
  input logic [btac_pkg::xlen-1:0] issue_tnpc,
  input logic execute_taken,
  input logic [btac_pkg::xlen-1:0] execute_taddr,
  input logic [btac_pkg::xlen-1:0] execute_tpc,
  input logic [btac_pkg::xlen-1:0] execute_tnpc,
  input logic memory_taken,
  input logic [btac_pkg::xlen-1:0] memory_taddr,
  input logic [btac_pkg::xlen-1:0] memory_tpc,
  input logic [btac_pkg::xlen-1:0] memory_tnpc,
  output logic pred_branch,
  output logic [btac_pkg::xlen-1:0] pred_baddr,
  output logic [btac_pkg::xlen-1:0] pred_pc,
  output logic [btac_pkg::xlen-1:0] pred_npc,
  output logic pred_miss,
  output logic [btac_pkg::xlen-1:0] pred_maddr
);

  btb_if btb_bus ();

  btb btb_i (
    .clock (clock),
    .bus (btb_bus.storage)
  );

  btac_lookup lookup_i (
    .clock (clock),
    .reset (reset),
    .stall (stall),
    .clear (clear),
    .get_pc0 (get_pc0),
    .get_pc1 (get_pc1),
    .bus (btb_bus.reader),
    .pred_branch (pred_branch),
    .pred_baddr (pred_baddr),
    .pred_pc (pred_pc),
    .pred_npc (pred_npc)
  );

  btac_resolve resolve_i (
    .clock (clock),
    .reset (reset),
    .clear (clear),
    .upd_pc0 (upd_pc0),
    .upd_npc0 (upd_npc0),
    .upd_addr0 (upd_addr0),
    .upd_jal0 (upd_jal0),
    .upd_branch0 (upd_branch0),
    .upd_jump0 (upd_jump0),
    .upd_pc1 (upd_pc1),
    .upd_npc1 (upd_npc1),
    .upd_addr1 (upd_addr1),
    .upd_jal1 (upd_jal1),
    .upd_branch1 (upd_branch1),
    .upd_jump1 (upd_jump1),
    .fetch_taken (fetch_taken),
    .fetch_taddr (fetch_taddr),
    .fetch_tpc (fetch_tpc),
    .fetch_tnpc (fetch_tnpc),
    .decode_taken (decode_taken),
    .decode_taddr (decode_taddr),
    .decode_tpc (decode_tpc),
    .decode_tnpc (decode_tnpc),
    .issue_taken (issue_taken),
    .issue_taddr (issue_taddr),
    .issue_tpc (issue_tpc),
    .issue_tnpc (issue_tnpc),
    .execute_taken (execute_taken),
    .execute_taddr (execute_taddr),
    .execute_tpc (execute_tpc),
    .execute_tnpc (execute_tnpc),
    .memory_taken (memory_taken),
    .memory_taddr (memory_taddr),
    .memory_tpc (memory_tpc),
    .memory_tnpc (memory_tnpc),
    .bus (btb_bus.writer),
    .pred_miss (pred_miss),
    .pred_maddr (pred_maddr)
  );

endmodule

// File: verilog/btac_resolve.sv
module btac_resolve (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic [btac_pkg::xlen-1:0] upd_pc0,
  input logic [btac_pkg::xlen-1:0] upd_npc0,
  input logic [btac_pkg::xlen-1:0] upd_addr0,
  input logic upd_jal0,
  input logic upd_branch0,
  input logic upd_jump0,
  input logic [btac_pkg::xlen-1:0] upd_pc1,
  input logic [btac_pkg::xlen-1:0] upd_npc1,
  input logic [btac_pkg::xlen-1:0] upd_addr1,
  input logic upd_jal1,
  input logic upd_branch1,
  input logic upd_jump1,
  input logic fetch_taken,
  input logic [btac_pkg::xlen-1:0] fetch_taddr,
  input logic [btac_pkg::xlen-1:0] fetch_tpc,
  input logic [btac_pkg::xlen-1:0] fetch_tnpc,
  input logic decode_taken,
  input logic [btac_pkg::xlen-1:0] decode_taddr,
  input logic [btac_pkg::xlen-1:0] decode_tpc,
  input logic [btac_pkg::xlen-1:0] decode_tnpc,
  input logic issue_taken,
  input logic [btac_pkg::xlen-1:0] issue_taddr,
  input logic [btac_pkg::xlen-1:0] issue_tpc,
  input logic [btac_pkg::xlen-1:0] issue_tnpc,
  input logic execute_taken,
  input logic [btac_pkg::xlen-1:0] execute_taddr,
  input logic [btac_pkg::xlen-1:0] execute_tpc,
  input logic [btac_pkg::xlen-1:0] execute_tnpc,
  input logic memory_taken,
  input logic [btac_pkg::xlen-1:0] memory_taddr,
  input logic [btac_pkg::xlen-1:0] memory_tpc,
  input logic [btac_pkg::xlen-1:0] memory_tnpc,
  btb_if.writer bus,
  output logic pred_miss,
  output logic [btac_pkg::xlen-1:0] pred_maddr
);

  // most recent taken prediction reported by any stage
  typedef struct packed {
    logic taken;
    logic [btac_pkg::xlen-1:0] taddr;
    logic [btac_pkg::xlen-1:0] tpc;
    logic [btac_pkg::xlen-1:0] tnpc;
  } record_t;

  record_t rec_q;
  record_t rec_d;
  logic match0;
  logic match1;

  // only a resolved jump writes, slot 0 supplies the entry if it jumped
  always_comb begin
    if (clear) begin
      bus.wen = 1'b0;
      bus.waddr = '0;
      bus.wdata = '0;
    end else begin
      bus.wen = ((upd_jal0 | upd_branch0) & upd_jump0) |
                ((upd_jal1 | upd_branch1) & upd_jump1);
      if (upd_jump0) begin
        bus.waddr = upd_pc0[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
        bus.wdata = {upd_addr0, upd_pc0, upd_npc0};
      end else begin
        bus.waddr = upd_pc1[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
        bus.wdata = {upd_addr1, upd_pc1, upd_npc1};
      end
    end
  end

  // later stages are older instructions and override earlier ones
  always_comb begin
    rec_d = rec_q;
    if (memory_taken) begin
      rec_d = '{1'b1, memory_taddr, memory_tpc, memory_tnpc};
    end else if (execute_taken) begin
      rec_d = '{1'b1, execute_taddr, execute_tpc, execute_tnpc};
    end else if (issue_taken) begin
      rec_d = '{1'b1, issue_taddr, issue_tpc, issue_tnpc};
    end else if (decode_taken) begin
      rec_d = '{1'b1, decode_taddr, decode_tpc, decode_tnpc};
    end else if (fetch_taken) begin
      rec_d = '{1'b1, fetch_taddr, fetch_tpc, fetch_tnpc};
    end

    match0 = rec_d.taken && (upd_pc0 == rec_d.tpc);
    match1 = rec_d.taken && (upd_pc1 == rec_d.tpc);

    pred_miss = 1'b0;
    pred_maddr = '0;
    if (match0) begin
      if (upd_jump0) begin
        pred_maddr = upd_addr0;
        pred_miss = (upd_addr0 != rec_d.taddr); // predicted but to the wrong target
        rec_d.taken = 1'b0;
      end else if (upd_branch0) begin
        pred_maddr = rec_d.tnpc; // predicted taken, resolved not taken
        pred_miss = 1'b1;
        rec_d.taken = 1'b0;
      end
    end else if (match1) begin
      if (upd_jump1) begin
        pred_maddr = upd_addr1;
        pred_miss = (upd_addr1 != rec_d.taddr);
        rec_d.taken = 1'b0;
      end else if (upd_branch1) begin
        pred_maddr = rec_d.tnpc;
        pred_miss = 1'b1;
        rec_d.taken = 1'b0;
      end
    end else if (upd_jump0) begin
      // a jump nobody predicted always redirects
      pred_maddr = upd_addr0;
      pred_miss = 1'b1;
      rec_d.taken = 1'b0;
    end else if (upd_jump1) begin
      pred_maddr = upd_addr1;
      pred_miss = 1'b1;
      rec_d.taken = 1'b0;
    end

    if (clear) begin
      pred_miss = 1'b0;
      pred_maddr = '0;
      rec_d = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      rec_q <= '0;
    end else begin
      rec_q <= rec_d;
    end
  end

endmodule

// File: verilog/btac_lookup.sv
module btac_lookup (
  input logic clock,
  input logic reset,
  input logic stall,
  input logic clear,
  input logic [btac_pkg::xlen-1:0] get_pc0,
  input logic [btac_pkg::xlen-1:0] get_pc1,
  btb_if.reader bus,
  output logic pred_branch,
  output logic [btac_pkg::xlen-1:0] pred_baddr,
  output logic [btac_pkg::xlen-1:0] pred_pc,
  output logic [btac_pkg::xlen-1:0] pred_npc
);

  logic [btac_pkg::xlen-1:0] pc0_q; // fetch PCs of the lookup in flight
  logic [btac_pkg::xlen-1:0] pc1_q;
  logic hit0;
  logic hit1;
  btac_pkg::btb_entry_t sel;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
    end else if (!clear) begin
      pc0_q <= get_pc0;
      pc1_q <= get_pc1;
    end
  end

  // while clear holds the PCs the array keeps reading the same entries
  always_comb begin
    if (clear) begin
      bus.raddr0 = pc0_q[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
      bus.raddr1 = pc1_q[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
    end else begin
      bus.raddr0 = get_pc0[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
      bus.raddr1 = get_pc1[btac_pkg::btb_index_msb:btac_pkg::btb_index_lsb];
    end
  end

  // an entry hits when it is not empty and its full PC matches the tag
  assign hit0 = (|bus.rdata0) && (bus.rdata0.pc == pc0_q);
  assign hit1 = (|bus.rdata1) && (bus.rdata1.pc == pc1_q);

  assign sel = hit0 ? bus.rdata0 : bus.rdata1; // slot 0 wins when both hit

  always_comb begin
    if (stall || clear) begin
      pred_branch = 1'b0;
      pred_baddr = '0;
      pred_pc = '0;
      pred_npc = '0;
    end else begin
      pred_branch = hit0 | hit1;
      pred_baddr = sel.target;
      pred_pc = sel.pc;
      pred_npc = sel.npc;
    end
  end

endmodule

// File: verilog/btb.sv
module btb (
  input logic clock,
  btb_if.storage bus
);

  // the array powers up empty so no stale target can hit
  btac_pkg::btb_entry_t mem [btac_pkg::btb_entries] = '{default: '0};

  logic [btac_pkg::btb_index_width-1:0] raddr0_q;
  logic [btac_pkg::btb_index_width-1:0] raddr1_q;

  always_ff @(posedge clock) begin
    raddr0_q <= bus.raddr0;
    raddr1_q <= bus.raddr1;
    if (bus.wen) begin
      mem[bus.waddr] <= bus.wdata;
    end
  end

  // read data follows the address captured at the previous edge, so a write in
  // the same cycle as the address is already visible here
  assign bus.rdata0 = mem[raddr0_q];
  assign bus.rdata1 = mem[raddr1_q];

endmodule

// File: verilog/btb_if.sv
interface btb_if;

  // write port, driven by the resolve logic
  logic wen;
  logic [btac_pkg::btb_index_width-1:0] waddr;
  btac_pkg::btb_entry_t wdata;

  // two read ports, addresses from the lookup logic and data from the array
  logic [btac_pkg::btb_index_width-1:0] raddr0;
  logic [btac_pkg::btb_index_width-1:0] raddr1;
  btac_pkg::btb_entry_t rdata0;
  btac_pkg::btb_entry_t rdata1;

  modport writer (
    output wen, waddr, wdata
  );

  modport reader (
    output raddr0, raddr1,
    input rdata0, rdata1
  );

  modport storage (
    input wen, waddr, wdata, raddr0, raddr1,
    output rdata0, rdata1
  );

endinterface

// File: verilog/btac_pkg.sv
package btac_pkg;

  // address and data width of the core
  localparam int xlen = 32;

  // direct-mapped target buffer geometry
  localparam int btb_entries = 64;
  localparam int btb_index_width = $clog2(btb_entries);

  // the index is taken from the word address, so the two low PC bits are skipped
  localparam int btb_index_lsb = 2;
  localparam int btb_index_msb = btb_index_lsb + btb_index_width - 1;

  // one buffer entry is 96 bits wide, the target sits in the top word
  // an entry that is all zero has never been written and counts as empty
  typedef struct packed {
    logic [xlen-1:0] target; // predicted branch target
    logic [xlen-1:0] pc;     // branch PC, compared as the tag
    logic [xlen-1:0] npc;    // fall-through address
  } btb_entry_t;

endpackage
